/* hw/uart_pkg.sv */
`default_nettype none

package uart_pkg;

	// data bits per frame, sent lsb first
	localparam int DATA_BITS = 8;

	// bit counter positions after the start bit
	// data bits take 0 .. DATA_BITS-1
	localparam int PAR_IDX  = DATA_BITS;
	localparam int STOP_IDX = DATA_BITS + 1;

	// error kind that travels with each received byte
	typedef enum logic [1:0] {
		ERR_NONE    = 2'd0,
		ERR_PARITY  = 2'd1,
		ERR_FRAMING = 2'd2,
		ERR_OVERRUN = 2'd3
	} rx_err_t;

endpackage

`default_nettype wire

/* hw/loader_pkg.sv */
`default_nettype none

package loader_pkg;

	// header field widths
	localparam int TAG_W  = 8;
	localparam int BASE_W = 12;
	localparam int CNT_W  = 12;

	// marks a valid header in the top byte of the first word
	localparam logic [TAG_W-1:0] LOAD_TAG = 8'hA5;

	// header view, tag sits in the top byte
	typedef struct packed {
		logic [TAG_W-1:0]  tag;
		logic [BASE_W-1:0] base;
		logic [CNT_W-1:0]  count;
	} load_hdr_t;

	// one received word, read as a header at the start of a transfer
	// and as plain program data after it
	typedef union packed {
		load_hdr_t   hdr;
		logic [31:0] raw;
	} loader_word_u;

endpackage

`default_nettype wire

/* hw/loader_ifs.sv */
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////
// byte stream, receiver to assembler
////////////////////////////////////////

interface rx_byte_if import uart_pkg::*; ();

	// byte moves when valid and ready are both high
	logic                 valid;
	logic                 ready;
	logic [DATA_BITS-1:0] data;
	// error kind of this byte, byte still transfers
	rx_err_t              err;

	modport source (
		output valid,
		output data,
		output err,
		input  ready
	);

	modport sink (
		input  valid,
		input  data,
		input  err,
		output ready
	);

endinterface

////////////////////////////////////////
// word stream, assembler to loader
////////////////////////////////////////

interface word_if ();

	logic        valid;
	logic        ready;
	logic [31:0] word;
	// stream broke here, word is meaningless
	logic        err;

	modport source (
		output valid,
		output word,
		output err,
		input  ready
	);

	modport sink (
		input  valid,
		input  word,
		input  err,
		output ready
	);

endinterface

`default_nettype wire

/* hw/uart_frame_rx.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_frame_rx import uart_pkg::*; (
	input  logic      dec_CLK,
	input  logic      nrst,
	input  logic      rx,
	rx_byte_if.source byte_bus
);

	// counter reaches the stop bit position
	localparam int CNT_W = $clog2(STOP_IDX + 1);

	logic                 busy;
	logic [CNT_W-1:0]     bit_cnt;
	logic [DATA_BITS-1:0] shift;
	logic                 par_bit;

	////////////////////////////////////////
	// frame sequencing
	////////////////////////////////////////

	always_ff @(posedge dec_CLK) begin
		if (nrst) begin
			busy           <= 1'b0;
			bit_cnt        <= '0;
			byte_bus.valid <= 1'b0;
			byte_bus.err   <= ERR_NONE;
		end else begin
			// held byte leaves on handshake
			if (byte_bus.valid && byte_bus.ready) begin
				byte_bus.valid <= 1'b0;
			end
			if (!busy) begin
				// line low while idle is a start bit
				if (!rx) begin
					busy    <= 1'b1;
					bit_cnt <= '0;
				end
			end else begin
				bit_cnt <= bit_cnt + CNT_W'(1);
				if (bit_cnt == CNT_W'(STOP_IDX)) begin
					busy           <= 1'b0;
					byte_bus.valid <= 1'b1;
					// old byte still unread, new one replaces it
					if (byte_bus.valid && !byte_bus.ready) begin
						byte_bus.err <= ERR_OVERRUN;
					end else if (^{shift, par_bit}) begin
						// even parity over data and parity bit
						byte_bus.err <= ERR_PARITY;
					end else if (!rx) begin
						byte_bus.err <= ERR_FRAMING;
					end else begin
						byte_bus.err <= ERR_NONE;
					end
				end
			end
		end
	end

	// shift register, lsb arrives first
	always_ff @(posedge dec_CLK) begin
		if (busy) begin
			if (bit_cnt < CNT_W'(PAR_IDX)) begin
				shift <= {rx, shift[DATA_BITS-1:1]};
			end
			if (bit_cnt == CNT_W'(PAR_IDX)) begin
				par_bit <= rx;
			end
			if (bit_cnt == CNT_W'(STOP_IDX)) begin
				byte_bus.data <= shift;
			end
		end
	end

	// waiting byte holds until taken, unless an overrun replaces it
	a_byte_hold: assert property (@(posedge dec_CLK) disable iff (nrst)
		byte_bus.valid && !byte_bus.ready |=>
			byte_bus.valid && ($stable(byte_bus.data) || byte_bus.err == ERR_OVERRUN));

endmodule

`default_nettype wire

/* hw/word_assembler.sv */
`timescale 1ns/1ns
`default_nettype none

module word_assembler import uart_pkg::*; (
	input  logic    dec_CLK,
	input  logic    nrst,
	rx_byte_if.sink byte_bus,
	word_if.source  word_bus
);

	// bytes per 32-bit word
	localparam int LANES = 32 / DATA_BITS;

	logic [2:0]                 lane;
	logic [LANES*DATA_BITS-1:0] acc;
	logic                       byte_xfer;

	// stall bytes only while a finished word waits
	assign byte_bus.ready = !word_bus.valid;
	assign byte_xfer      = byte_bus.valid && byte_bus.ready;
	assign word_bus.word  = acc;

	always_ff @(posedge dec_CLK) begin
		if (nrst) begin
			lane           <= '0;
			word_bus.valid <= 1'b0;
			word_bus.err   <= 1'b0;
		end else begin
			if (word_bus.valid && word_bus.ready) begin
				word_bus.valid <= 1'b0;
			end
			if (byte_xfer) begin
				if (byte_bus.err != ERR_NONE) begin
					// drop the partial word, flag the break
					lane           <= '0;
					word_bus.valid <= 1'b1;
					word_bus.err   <= 1'b1;
				end else if (lane == 3'(LANES - 1)) begin
					lane           <= '0;
					word_bus.valid <= 1'b1;
					word_bus.err   <= 1'b0;
				end else begin
					lane <= lane + 3'd1;
				end
			end
		end
	end

	// first byte lands in the low lane
	always_ff @(posedge dec_CLK) begin
		if (byte_xfer) begin
			acc[lane*DATA_BITS +: DATA_BITS] <= byte_bus.data;
		end
	end

	// lane count never passes the last lane
	a_lane_range: assert property (@(posedge dec_CLK) disable iff (nrst)
		lane <= 3'(LANES - 1));

endmodule

`default_nettype wire

/* hw/load_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module load_ctrl import loader_pkg::*; #(
	parameter int ADDR_W = 8
) (
	input  logic              dec_CLK,
	input  logic              nrst,
	word_if.sink              word_bus,
	output logic              we,
	output logic [ADDR_W-1:0] waddr,
	output logic [31:0]       wdata,
	output logic              load_done,
	output logic              load_err
);

	// FSM states
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_HDR  = 2'd1;
	localparam logic [1:0] ST_LOAD = 2'd2;

	logic [1:0]        state;
	loader_word_u      word_in;
	loader_word_u      hdr_q;
	logic [ADDR_W-1:0] addr;
	logic [CNT_W-1:0]  remaining;
	logic              xfer;

	// memory never stalls, so neither does the loader
	assign word_bus.ready = 1'b1;
	assign word_in.raw    = word_bus.word;
	assign xfer           = word_bus.valid && word_bus.ready;

	////////////////////////////////////////
	// control
	////////////////////////////////////////

	always_ff @(posedge dec_CLK) begin
		if (nrst) begin
			state     <= ST_IDLE;
			we        <= 1'b0;
			load_done <= 1'b0;
			load_err  <= 1'b0;
		end else begin
			we <= 1'b0;
			case (state)
				ST_IDLE: begin
					// any good word here is a header candidate
					if (xfer) begin
						if (word_bus.err) begin
							load_err <= 1'b1;
						end else begin
							load_done <= 1'b0;
							state     <= ST_HDR;
						end
					end
				end
				ST_HDR: begin
					if (hdr_q.hdr.tag != LOAD_TAG) begin
						load_err <= 1'b1;
						state    <= ST_IDLE;
					end else if (hdr_q.hdr.count == '0) begin
						// empty transfer is done at once
						load_done <= 1'b1;
						state     <= ST_IDLE;
					end else begin
						state <= ST_LOAD;
					end
				end
				ST_LOAD: begin
					if (xfer) begin
						if (word_bus.err) begin
							// abort, nothing more written until a good header
							load_err <= 1'b1;
							state    <= ST_IDLE;
						end else begin
							we <= 1'b1;
							if (remaining == CNT_W'(1)) begin
								load_done <= 1'b1;
								state     <= ST_IDLE;
							end
						end
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// header capture, address and count
	////////////////////////////////////////

	always_ff @(posedge dec_CLK) begin
		if (state == ST_IDLE && xfer) begin
			hdr_q <= word_in;
		end
		if (state == ST_HDR) begin
			addr      <= ADDR_W'(hdr_q.hdr.base);
			remaining <= hdr_q.hdr.count;
		end
		// data word goes out one cycle after it arrives
		if (state == ST_LOAD && xfer && !word_bus.err) begin
			waddr     <= addr;
			wdata     <= word_in.raw;
			addr      <= addr + ADDR_W'(1);
			remaining <= remaining - CNT_W'(1);
		end
	end

	// a write strobe only follows a loading cycle with words still to go
	a_we_load: assert property (@(posedge dec_CLK) disable iff (nrst)
		we |-> $past(state == ST_LOAD && remaining != '0));

endmodule

`default_nettype wire

/* hw/prog_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module prog_mem #(
	parameter int ADDR_W = 8
) (
	input  logic              dec_CLK,
	input  logic              we,
	input  logic [ADDR_W-1:0] waddr,
	input  logic [31:0]       wdata,
	input  logic [ADDR_W-1:0] rd_addr,
	output logic [31:0]       rd_data
);

	// one word per address, block RAM style
	logic [31:0] mem [2**ADDR_W];

	// write port from the loader
	always_ff @(posedge dec_CLK) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// registered read for fetch, one cycle after rd_addr
	always_ff @(posedge dec_CLK) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

/* hw/uart_loader_top.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_loader_top #(
	parameter int ADDR_W = 8
) (
	input  logic              dec_CLK,
	input  logic              nrst,
	input  logic              rx,
	input  logic [ADDR_W-1:0] rd_addr,
	output logic [31:0]       rd_data,
	output logic              load_done,
	output logic              load_err
);

	rx_byte_if byte_bus ();
	word_if    word_bus ();

	// loader to memory write port
	logic              we;
	logic [ADDR_W-1:0] waddr;
	logic [31:0]       wdata;

	// serial line to checked bytes
	uart_frame_rx i_rx (
		.dec_CLK  (dec_CLK),
		.nrst     (nrst),
		.rx       (rx),
		.byte_bus (byte_bus)
	);

	// bytes to 32-bit words
	word_assembler i_asm (
		.dec_CLK  (dec_CLK),
		.nrst     (nrst),
		.byte_bus (byte_bus),
		.word_bus (word_bus)
	);

	load_ctrl #(.ADDR_W(ADDR_W)) i_ctrl (
		.dec_CLK   (dec_CLK),
		.nrst      (nrst),
		.word_bus  (word_bus),
		.we        (we),
		.waddr     (waddr),
		.wdata     (wdata),
		.load_done (load_done),
		.load_err  (load_err)
	);

	prog_mem #(.ADDR_W(ADDR_W)) i_mem (
		.dec_CLK (dec_CLK),
		.we      (we),
		.waddr   (waddr),
		.wdata   (wdata),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

endmodule

`default_nettype wire

/* tb/loader_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module loader_checker #(
	parameter int ADDR_W = 8
) (
	input  logic              dec_CLK,
	// DUT ports under watch
	input  logic [ADDR_W-1:0] rd_addr,
	input  logic [31:0]       rd_data,
	input  logic              load_done,
	input  logic              load_err,
	// compare requests from the stimulus side
	input  logic              chk_mem,
	input  logic [31:0]       exp_data,
	input  logic              chk_stat,
	input  logic              exp_done,
	input  logic              exp_err,
	output int                mem_errs,
	output int                stat_errs
);

	// read in flight, memory answers one cycle later
	logic              pend = 1'b0;
	logic [ADDR_W-1:0] pend_addr;
	logic [31:0]       pend_data;
	int                mem_cnt = 0;
	int                stat_cnt = 0;

	assign mem_errs  = mem_cnt;
	assign stat_errs = stat_cnt;

	////////////////////////////////////////
	// memory read-back
	////////////////////////////////////////

	always_ff @(posedge dec_CLK) begin
		pend <= chk_mem;
		if (chk_mem) begin
			pend_addr <= rd_addr;
			pend_data <= exp_data;
		end
		// rd_data here belongs to the address of the previous cycle
		if (pend && rd_data !== pend_data) begin
			$display("ERR rd_data[%h]: expected %h, got %h", pend_addr, pend_data, rd_data);
			mem_cnt <= mem_cnt + 1;
		end
	end

	////////////////////////////////////////
	// status ports
	////////////////////////////////////////

	always_ff @(posedge dec_CLK) begin
		if (chk_stat && load_done !== exp_done) begin
			$display("ERR load_done: expected %h, got %h", exp_done, load_done);
		end
		if (chk_stat && load_err !== exp_err) begin
			$display("ERR load_err: expected %h, got %h", exp_err, load_err);
		end
		// one count per status check, whichever port was off
		if (chk_stat && (load_done !== exp_done || load_err !== exp_err)) begin
			stat_cnt <= stat_cnt + 1;
		end
	end

endmodule

`default_nettype wire

/* tb/tb_uart_loader.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_uart_loader;

	localparam int    ADDR_W     = 8;
	localparam int    CLK_NS     = 4;
	// cycles allowed for one status wait
	localparam int    WAIT_LIMIT = 200;
	localparam string STIM_FILE  = "tb/loader_stimulus.txt";

	logic              dec_CLK;
	logic              nrst;
	logic              rx;
	logic [ADDR_W-1:0] rd_addr;
	logic [31:0]       rd_data;
	logic              load_done;
	logic              load_err;

	// requests to the checker
	logic        chk_mem;
	logic [31:0] exp_data;
	logic        chk_stat;
	logic        exp_done;
	logic        exp_err;
	int          mem_errs;
	int          stat_errs;
	// failures that are not a wrong value
	int          run_errs;
	int          limit_ns;

	string lines [$];

	uart_loader_top #(.ADDR_W(ADDR_W)) i_dut (
		.dec_CLK   (dec_CLK),
		.nrst      (nrst),
		.rx        (rx),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data),
		.load_done (load_done),
		.load_err  (load_err)
	);

	loader_checker #(.ADDR_W(ADDR_W)) i_chk (
		.dec_CLK   (dec_CLK),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data),
		.load_done (load_done),
		.load_err  (load_err),
		.chk_mem   (chk_mem),
		.exp_data  (exp_data),
		.chk_stat  (chk_stat),
		.exp_done  (exp_done),
		.exp_err   (exp_err),
		.mem_errs  (mem_errs),
		.stat_errs (stat_errs)
	);

	initial begin
		dec_CLK = 1'b0;
		forever #(CLK_NS / 2) dec_CLK = ~dec_CLK;
	end

	////////////////////////////////////////
	// serial line and read-back
	////////////////////////////////////////

	// hold the DUT in reset for 16 cycles
	task automatic apply_reset();
		nrst = 1'b1;
		repeat (16) @(negedge dec_CLK);
		nrst = 1'b0;
	endtask

	// start bit, data lsb first, even parity, stop, then idle gap
	task automatic send_frame(input logic [7:0] b, input logic par_flip, input logic stop_low);
		int gap;
		gap = int'($urandom % 6);
		@(negedge dec_CLK);
		rx = 1'b0;
		for (int i = 0; i < 8; i++) begin
			@(negedge dec_CLK);
			rx = b[i];
		end
		@(negedge dec_CLK);
		rx = (^b) ^ par_flip;
		@(negedge dec_CLK);
		rx = !stop_low;
		for (int i = 0; i < gap; i++) begin
			@(negedge dec_CLK);
			rx = 1'b1;
		end
	endtask

	// line back to idle, wait for the expected status, then have it checked
	task automatic wait_status(input logic d, input logic e);
		int cycles;
		cycles = 0;
		@(negedge dec_CLK);
		rx = 1'b1;
		while ((load_done !== d || load_err !== e) && cycles < WAIT_LIMIT) begin
			@(negedge dec_CLK);
			cycles++;
		end
		if (load_done !== d || load_err !== e) begin
			$display("status did not reach done=%0b err=%0b within %0d cycles", d, e, WAIT_LIMIT);
			run_errs++;
		end
		exp_done = d;
		exp_err  = e;
		chk_stat = 1'b1;
		@(negedge dec_CLK);
		chk_stat = 1'b0;
	endtask

	task automatic check_word(input logic [ADDR_W-1:0] a, input logic [31:0] w);
		@(negedge dec_CLK);
		rd_addr  = a;
		exp_data = w;
		chk_mem  = 1'b1;
		@(negedge dec_CLK);
		chk_mem  = 1'b0;
	endtask

	////////////////////////////////////////
	// stimulus file lines
	////////////////////////////////////////

	function automatic int frames_in(input string line);
		string      kind;
		logic [7:0] fb [4];
		int         fp [4];
		int         fs [4];
		int         n;
		n = $sscanf(line, "%s", kind);
		if (n < 1 || kind != "S") begin
			return 0;
		end
		n = $sscanf(line, "S %h %d %d %h %d %d %h %d %d %h %d %d",
			fb[0], fp[0], fs[0], fb[1], fp[1], fs[1],
			fb[2], fp[2], fs[2], fb[3], fp[3], fs[3]);
		return n / 3;
	endfunction

	// comment and blank lines fall through
	task automatic run_line(input string line);
		string       kind;
		int          n;
		logic [7:0]  fb [4];
		int          fp [4];
		int          fs [4];
		logic [31:0] ea;
		logic [31:0] ew;
		int          d;
		int          e;
		n = $sscanf(line, "%s", kind);
		if (n >= 1 && kind == "S") begin
			n = $sscanf(line, "S %h %d %d %h %d %d %h %d %d %h %d %d",
				fb[0], fp[0], fs[0], fb[1], fp[1], fs[1],
				fb[2], fp[2], fs[2], fb[3], fp[3], fs[3]);
			for (int i = 0; i < n / 3; i++) begin
				send_frame(fb[i], fp[i] != 0, fs[i] != 0);
			end
		end else if (n >= 1 && kind == "E") begin
			void'($sscanf(line, "E %h %h", ea, ew));
			check_word(ea[ADDR_W-1:0], ew);
		end else if (n >= 1 && kind == "T") begin
			void'($sscanf(line, "T %d %d", d, e));
			wait_status(d != 0, e != 0);
			// control starts clean for the next transfer, memory keeps its words
			apply_reset();
		end
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		int    fd;
		int    frames;
		string line;
		rx       = 1'b1;
		nrst     = 1'b1;
		rd_addr  = '0;
		chk_mem  = 1'b0;
		exp_data = '0;
		chk_stat = 1'b0;
		exp_done = 1'b0;
		exp_err  = 1'b0;
		run_errs = 0;
		limit_ns = 0;
		frames   = 0;
		void'($urandom(6706));

		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("cannot open stimulus file %s", STIM_FILE);
			run_errs++;
		end else begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) > 0) begin
					lines.push_back(line);
				end
			end
			$fclose(fd);
		end
		foreach (lines[i]) begin
			frames += frames_in(lines[i]);
		end
		// worst case frame with gap is 16 bits, each line may use a full wait and a reset
		limit_ns = (16 + frames * 16 + lines.size() * (WAIT_LIMIT + 16) + 64) * CLK_NS;

		apply_reset();

		foreach (lines[i]) begin
			run_line(lines[i]);
		end
		// let the last read-back reach the checker
		repeat (2) @(negedge dec_CLK);

		$display("error counts: memory %0d, status %0d, other %0d",
			mem_errs, stat_errs, run_errs);
		if (mem_errs + stat_errs + run_errs == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// watchdog
	initial begin
		wait (limit_ns > 0);
		#(limit_ns);
		$display("watchdog expired after %0d ns, the run did not finish", limit_ns);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/loader_stimulus.txt */
# S: one to four frames as byte(hex) parity(0 good, 1 flipped) stop(0 good, 1 low)
# E: address(hex) expected word(hex)    T: expected load_done load_err
T 0 0
# header a5010003, then three words into 0x10
S 03 0 0 00 0 0 01 0 0 a5 0 0
S fa 0 0 de 0 0 da 0 0 e1 0 0
S df 0 0 9b 0 0 57 0 0 13 0 0
S e0 0 0 ac 0 0 68 0 0 24 0 0
T 1 0
E 10 e1dadefa
E 11 13579bdf
E 12 2468ace0
# header a5010002, second word has a parity error in its last byte
S 02 0 0 00 0 0 01 0 0 a5 0 0
S e0 0 0 fe 0 0 0f 0 0 0c 0 0
S 11 0 0 22 0 0 33 0 0 44 1 0
T 0 1
E 10 0c0ffee0
E 11 13579bdf
# header a5011002, second word has a low stop bit in its last byte
S 02 0 0 10 0 0 01 0 0 a5 0 0
S 0d 0 0 f0 0 0 fe 0 0 ca 0 0
S 55 0 0 66 0 0 77 0 0 88 0 1
T 0 1
E 11 cafef00d
E 12 2468ace0
# bad tag 5a012001 and its data word, then a good load into 0x20
S 01 0 0 20 0 0 01 0 0 5a 0 0
S 0d 0 0 f0 0 0 ad 0 0 0b 0 0
S 02 0 0 00 0 0 02 0 0 a5 0 0
S ef 0 0 cd 0 0 ab 0 0 89 0 0
S 10 0 0 32 0 0 54 0 0 76 0 0
T 1 1
E 12 2468ace0
E 20 89abcdef
E 21 76543210

/* uart_loader.f */
hw/uart_pkg.sv
hw/loader_pkg.sv
hw/loader_ifs.sv
hw/uart_frame_rx.sv
hw/word_assembler.sv
hw/load_ctrl.sv
hw/prog_mem.sv
hw/uart_loader_top.sv
tb/loader_checker.sv
tb/tb_uart_loader.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and pass only if the pass message shows up
verilator --binary --assert -f uart_loader.f --top-module tb_uart_loader -o sim_uart_loader &&
	out=$(./obj_dir/sim_uart_loader) &&
	echo "$out" &&
	echo "$out" | grep -qx "No errors" &&
	echo "PASS" || { echo "FAIL"; exit 1; }
